// ==== filelist.f ====
+incdir+source
source/serv_pkg.sv
source/serv_intf.sv
source/serv_state.sv
source/serv_decode.sv
source/serv_alu.sv
source/serv_ctrl.sv
source/serv_rf_if.sv
source/serv_top.sv
sim/serv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps --top-module serv_tb \
   -f filelist.f -o serv_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/serv_sim)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== sim/serv_tb.sv ====
`timescale 1ns/10ps
`include "serv_params.svh"

module serv_tb
   import serv_pkg::*;
();

   localparam int         WAIT_LIMIT = 20;
   localparam word_t      LFSR_SEED  = 32'h89a4_ed13;
   localparam logic [2:0] F3_ADD     = 3'b000;
   localparam logic [2:0] F3_BNE     = 3'b001;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [6:0] F7_SUB     = 7'b0100000;

   logic      clk;
   logic      i_rst_n;
   logic      o_rf_rreq;
   logic      i_rf_ready;
   reg_addr_t o_rreg0;
   reg_addr_t o_rreg1;
   logic      i_rdata0;
   logic      i_rdata1;
   reg_addr_t o_wreg0;
   logic      o_wen0;
   logic      o_wdata0;
   word_t     o_ibus_adr;
   logic      o_ibus_cyc;
   word_t     i_ibus_rdt;
   logic      i_ibus_ack;

   word_t     lfsr_q;
   int        errors;
   int        rows_done;
   logic      timed_out;
   word_t     regs [32];

   // Program table with one entry per executed instruction
   word_t     tab_addr [$];
   word_t     tab_instr [$];
   reg_addr_t tab_rd [$];
   word_t     tab_val [$];
   logic      tab_wr [$];

   serv_top uut (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // RV32I encoders
   function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, reg_addr_t rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t enc_i(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                   logic [11:0] imm);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic word_t enc_b(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                   logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic word_t enc_j(reg_addr_t rd, logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   // Taps 32, 22, 2, 1
   function automatic word_t lfsr_step(word_t s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_delay(output int d);
      int b;
      d = 0;
      for (b = 0; b < 2; b++) begin
         lfsr_q = lfsr_step(lfsr_q);
         d = d * 2;
         if (lfsr_q[0]) begin
            d = d + 1;
         end
      end
   endtask

   task automatic add_row(input word_t a, input word_t instr, input reg_addr_t rd,
                          input word_t val, input logic wr);
      tab_addr.push_back(a);
      tab_instr.push_back(instr);
      tab_rd.push_back(rd);
      tab_val.push_back(val);
      tab_wr.push_back(wr);
   endtask

   task automatic build_table();
      word_t b;
      b = `SERV_RESET_PC;
      add_row(b + 32'h00, enc_i(F3_ADD, 5'd1, 5'd0, -12'sd1), 5'd1, 32'hFFFF_FFFF, 1'b1);
      add_row(b + 32'h04, enc_i(F3_ADD, 5'd2, 5'd1, 12'd1), 5'd2, 32'h0000_0000, 1'b1);
      add_row(b + 32'h08, {20'h12345, 5'd3, 7'b0110111}, 5'd3, 32'h1234_5000, 1'b1);
      add_row(b + 32'h0C, enc_i(F3_ADD, 5'd3, 5'd3, 12'h678), 5'd3, 32'h1234_5678, 1'b1);
      add_row(b + 32'h10, enc_i(F3_XOR, 5'd4, 5'd3, -12'sd1), 5'd4, 32'hEDCB_A987, 1'b1);
      add_row(b + 32'h14, enc_i(F3_OR, 5'd5, 5'd3, 12'h0F0), 5'd5, 32'h1234_56F8, 1'b1);
      add_row(b + 32'h18, enc_i(F3_AND, 5'd6, 5'd3, -12'sd256), 5'd6, 32'h1234_5600, 1'b1);
      add_row(b + 32'h1C, enc_r(7'd0, F3_ADD, 5'd7, 5'd3, 5'd4), 5'd7, 32'hFFFF_FFFF, 1'b1);
      add_row(b + 32'h20, enc_r(F7_SUB, F3_ADD, 5'd8, 5'd5, 5'd3), 5'd8, 32'h0000_0080, 1'b1);
      add_row(b + 32'h24, enc_r(F7_SUB, F3_ADD, 5'd9, 5'd3, 5'd5), 5'd9, 32'hFFFF_FF80, 1'b1);
      add_row(b + 32'h28, enc_r(7'd0, F3_AND, 5'd10, 5'd4, 5'd5), 5'd10, 32'h0000_0080, 1'b1);
      add_row(b + 32'h2C, enc_r(7'd0, F3_OR, 5'd11, 5'd3, 5'd4), 5'd11, 32'hFFFF_FFFF, 1'b1);
      add_row(b + 32'h30, enc_r(7'd0, F3_XOR, 5'd12, 5'd5, 5'd6), 5'd12, 32'h0000_00F8, 1'b1);
      // Write to x0 and a later read of x0
      add_row(b + 32'h34, enc_i(F3_ADD, 5'd0, 5'd1, 12'd5), 5'd0, 32'h0, 1'b0);
      add_row(b + 32'h38, enc_r(7'd0, F3_ADD, 5'd13, 5'd0, 5'd12), 5'd13, 32'h0000_00F8, 1'b1);
      // LW x14, 0(x1) is not supported
      add_row(b + 32'h3C, 32'h0000_A703, 5'd14, 32'h0, 1'b0);
      add_row(b + 32'h40, enc_b(F3_ADD, 5'd1, 5'd7, 13'd8), 5'd0, 32'h0, 1'b0);
      add_row(b + 32'h48, enc_b(F3_BNE, 5'd1, 5'd7, 13'd8), 5'd0, 32'h0, 1'b0);
      add_row(b + 32'h4C, enc_b(F3_ADD, 5'd3, 5'd5, 13'd12), 5'd0, 32'h0, 1'b0);
      add_row(b + 32'h50, enc_b(F3_BNE, 5'd3, 5'd5, 13'd12), 5'd0, 32'h0, 1'b0);
      add_row(b + 32'h5C, enc_j(5'd15, 21'd20), 5'd15, b + 32'h60, 1'b1);
      add_row(b + 32'h70, enc_b(F3_BNE, 5'd2, 5'd0, 13'd8), 5'd0, 32'h0, 1'b0);
      add_row(b + 32'h74, enc_j(5'd0, -21'sd16), 5'd0, 32'h0, 1'b0);
      add_row(b + 32'h64, enc_r(7'd0, F3_ADD, 5'd16, 5'd15, 5'd13), 5'd16, b + 32'h158, 1'b1);
      add_row(b + 32'h68, enc_b(F3_ADD, 5'd16, 5'd16, 13'd32), 5'd0, 32'h0, 1'b0);
      add_row(b + 32'h88, enc_i(F3_ADD, 5'd17, 5'd16, -12'sd344), 5'd17, b, 1'b1);
      // LUI whose rs1 field selects x1, which holds all ones
      add_row(b + 32'h8C, {20'hABC0F, 5'd18, 7'b0110111}, 5'd18, 32'hABC0_F000, 1'b1);
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      errors++;
      timed_out = 1'b1;
      $display("Timeout: no %s within %0d cycles at %0t", what, WAIT_LIMIT, $time);
   endtask

   task automatic wait_fetch(output logic ok);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (o_wen0) begin
            errors++;
            $display("Write enable active outside execute at %0t", $time);
         end
      end while (!o_ibus_cyc && n < WAIT_LIMIT);
      ok = o_ibus_cyc;
      if (!ok) begin
         report_timeout("instruction fetch");
      end
   endtask

   task automatic run_row(input int r);
      int        d;
      int        n;
      int        k;
      int        wr_cnt;
      int        err_before;
      logic      ok;
      word_t     rs1_val;
      word_t     rs2_val;
      word_t     wval;
      reg_addr_t wreg;

      err_before = errors;
      wait_fetch(ok);
      if (!ok) begin
         return;
      end
      if (r == 0) begin
         check_word("first fetch address", o_ibus_adr, `SERV_RESET_PC);
      end
      check_word($sformatf("row %0d fetch address", r), o_ibus_adr, tab_addr[r]);

      // Bus model acks after a random delay
      random_delay(d);
      repeat (d) begin
         @(posedge clk);
         if (!o_ibus_cyc) begin
            errors++;
            $display("Row %0d: fetch request dropped before ack at %0t", r, $time);
         end
      end
      i_ibus_rdt <= tab_instr[r];
      i_ibus_ack <= 1'b1;
      @(posedge clk);
      i_ibus_ack <= 1'b0;

      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!o_rf_rreq && n < WAIT_LIMIT);
      if (!o_rf_rreq) begin
         report_timeout("register read request");
         return;
      end
      if (o_ibus_cyc) begin
         errors++;
         $display("Row %0d: fetch request still active after ack at %0t", r, $time);
      end

      // Register file model captures the operands at the request
      rs1_val = regs[o_rreg0];
      rs2_val = regs[o_rreg1];
      random_delay(d);
      repeat (d) @(posedge clk);
      i_rf_ready <= 1'b1;
      @(posedge clk);
      i_rf_ready <= 1'b0;

      wr_cnt = 0;
      wval   = '0;
      wreg   = '0;
      for (k = 0; k < `SERV_XLEN; k++) begin
         i_rdata0 <= rs1_val[k];
         i_rdata1 <= rs2_val[k];
         @(posedge clk);
         if (o_wen0) begin
            wr_cnt++;
            wreg    = o_wreg0;
            wval[k] = o_wdata0;
         end
      end

      if (tab_wr[r]) begin
         if (wr_cnt != `SERV_XLEN) begin
            errors++;
            $display("Row %0d: %0d write cycles seen, expected 32", r, wr_cnt);
         end
         check_reg($sformatf("row %0d write register", r), wreg, tab_rd[r]);
         check_word($sformatf("row %0d write value", r), wval, tab_val[r]);
      end else if (wr_cnt != 0) begin
         errors++;
         $display("Row %0d: %0d write cycles seen, expected none", r, wr_cnt);
      end
      if (wr_cnt > 0 && wreg != '0) begin
         regs[wreg] = wval;
      end
      rows_done++;
      $display("row %0d at %h: %s", r, tab_addr[r], (errors == err_before) ? "ok" : "mismatch");
   endtask

   initial begin
      int   r;
      logic ok;

      i_rst_n    <= 1'b0;
      i_rf_ready <= 1'b0;
      i_rdata0   <= 1'b0;
      i_rdata1   <= 1'b0;
      i_ibus_rdt <= '0;
      i_ibus_ack <= 1'b0;
      lfsr_q    = LFSR_SEED;
      errors    = 0;
      rows_done = 0;
      timed_out = 1'b0;
      for (r = 0; r < 32; r++) begin
         regs[r] = '0;
      end
      build_table();

      repeat (8) begin
         @(posedge clk);
         if (o_ibus_cyc || o_rf_rreq || o_wen0) begin
            errors++;
            $display("Bus request or write active during reset at %0t", $time);
         end
      end
      i_rst_n <= 1'b1;

      for (r = 0; r < tab_addr.size() && !timed_out; r++) begin
         run_row(r);
      end
      if (!timed_out) begin
         wait_fetch(ok);
         if (ok) begin
            check_word("final fetch address", o_ibus_adr, `SERV_RESET_PC + 32'h90);
         end
      end

      $display("%0d of %0d rows run, %0d errors", rows_done, tab_addr.size(), errors);
      if (errors == 0 && !timed_out) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== source/serv_top.sv ====
`timescale 1ns/10ps

module serv_top
   import serv_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   // Register file
   output logic      o_rf_rreq,
   input  logic      i_rf_ready,
   output reg_addr_t o_rreg0,
   output reg_addr_t o_rreg1,
   input  logic      i_rdata0,
   input  logic      i_rdata1,
   output reg_addr_t o_wreg0,
   output logic      o_wen0,
   output logic      o_wdata0,
   // Instruction bus
   output word_t     o_ibus_adr,
   output logic      o_ibus_cyc,
   input  word_t     i_ibus_rdt,
   input  logic      i_ibus_ack
);

   logic      take_branch;
   logic      jump;
   logic      rd_en;
   reg_addr_t rd_addr;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   logic      alu_rd;
   logic      ctrl_rd;

   serv_cnt_if cnt_bus ();
   serv_alu_if alu_bus ();

   serv_state state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .cnt        (cnt_bus.state)
   );

   serv_decode decode (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .cnt           (cnt_bus.user),
      .alu           (alu_bus.decode),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_rd_en       (rd_en),
      .o_branch_op   (),
      .o_jump        (jump),
      .o_take_branch (take_branch)
   );

   serv_alu alu (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .cnt     (cnt_bus.user),
      .alu     (alu_bus.alu),
      .i_rs1   (i_rdata0),
      .i_rs2   (i_rdata1),
      .o_rd    (alu_rd)
   );

   serv_ctrl ctrl (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .cnt           (cnt_bus.user),
      .i_imm_bit     (alu_bus.imm_bit),
      .i_jump        (jump),
      .i_take_branch (take_branch),
      .o_ctrl_rd     (ctrl_rd),
      .o_ibus_adr    (o_ibus_adr)
   );

   serv_rf_if rf_if (
      .cnt        (cnt_bus.user),
      .i_rd_en    (rd_en),
      .i_rd_addr  (rd_addr),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_sel   (alu_bus.rd_sel),
      .i_alu_rd   (alu_rd),
      .i_ctrl_rd  (ctrl_rd),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1)
   );

endmodule

// ==== source/serv_rf_if.sv ====
`timescale 1ns/10ps

module serv_rf_if
   import serv_pkg::*;
(
   serv_cnt_if.user  cnt,
   input  logic      i_rd_en,
   input  reg_addr_t i_rd_addr,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   input  rd_sel_t   i_rd_sel,
   input  logic      i_alu_rd,
   input  logic      i_ctrl_rd,
   output reg_addr_t o_wreg0,
   output logic      o_wen0,
   output logic      o_wdata0,
   output reg_addr_t o_rreg0,
   output reg_addr_t o_rreg1
);

   assign o_rreg0 = i_rs1_addr;
   assign o_rreg1 = i_rs2_addr;
   assign o_wreg0 = i_rd_addr;

   // Writes to x0 are dropped here
   assign o_wen0 = cnt.cnt_en & i_rd_en & (i_rd_addr != '0);

   assign o_wdata0 = (i_rd_sel == RD_CTRL) ? i_ctrl_rd : i_alu_rd;

endmodule

// ==== source/serv_ctrl.sv ====
`timescale 1ns/10ps
`include "serv_params.svh"

module serv_ctrl
   import serv_pkg::*;
(
   input  logic     clk,
   input  logic     i_rst_n,
   serv_cnt_if.user cnt,
   input  logic     i_imm_bit,
   input  logic     i_jump,
   input  logic     i_take_branch,
   output logic     o_ctrl_rd,
   output word_t    o_ibus_adr
);

   function automatic logic carry_of(logic a, logic b, logic c);
      return (a & b) | (c & (a ^ b));
   endfunction

   word_t pc_q;
   word_t plus4_q;
   word_t offset_q;
   logic  pc_bit;
   logic  four_bit;
   logic  c4_in;
   logic  c4_q;
   logic  sum4;
   logic  coff_in;
   logic  coff_q;
   logic  sum_off;
   logic  upd_q;

   assign pc_bit   = pc_q[cnt.cnt];
   assign four_bit = (cnt.cnt == cnt_t'(2));

   // PC+4 and PC+offset, both starting with zero carry
   assign c4_in   = ~cnt.init & c4_q;
   assign sum4    = pc_bit ^ four_bit ^ c4_in;
   assign coff_in = ~cnt.init & coff_q;
   assign sum_off = pc_bit ^ i_imm_bit ^ coff_in;

   always_ff @(posedge clk) begin
      if (cnt.cnt_en) begin
         plus4_q  <= {sum4, plus4_q[31:1]};
         offset_q <= {sum_off, offset_q[31:1]};
         c4_q     <= carry_of(pc_bit, four_bit, c4_in);
         coff_q   <= carry_of(pc_bit, i_imm_bit, coff_in);
      end
   end

   // PC update in the cycle after the last serial bit
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q  <= `SERV_RESET_PC;
         upd_q <= 1'b0;
      end else begin
         upd_q <= cnt.done;
         if (upd_q) begin
            pc_q <= (i_jump | i_take_branch) ? offset_q : plus4_q;
         end
      end
   end

   // Return address for JAL
   assign o_ctrl_rd  = sum4;
   assign o_ibus_adr = pc_q;

   assert property (@(posedge clk) disable iff (!i_rst_n)
      upd_q |=> (o_ibus_adr[1:0] == 2'b00));

endmodule

// ==== source/serv_alu.sv ====
`timescale 1ns/10ps

module serv_alu
   import serv_pkg::*;
(
   input  logic     clk,
   input  logic     i_rst_n,
   serv_cnt_if.user cnt,
   serv_alu_if.alu  alu,
   input  logic     i_rs1,
   input  logic     i_rs2,
   output logic     o_rd
);

   logic op_a;
   logic op_b;
   logic b_inv;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic ne;
   logic bool_res;

   // Operand a forced to zero for LUI
   assign op_a  = i_rs1 & ~alu.op_a_zero;
   assign op_b  = alu.op_b_imm ? alu.imm_bit : i_rs2;
   assign b_inv = op_b ^ alu.sub;

   // Carry preset to one completes the two's complement of b
   assign carry_in = cnt.init ? alu.sub : carry_q;
   assign sum      = op_a ^ b_inv ^ carry_in;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (cnt.cnt_en) begin
         carry_q <= (op_a & b_inv) | (carry_in & (op_a ^ b_inv));
      end
   end

   assign ne         = i_rs1 ^ op_b;
   assign alu.cmp_eq = ~ne;

   always_comb begin
      case (alu.bool_op)
         BOOL_XOR:  bool_res = ne;
         BOOL_PASS: bool_res = op_b;
         BOOL_OR:   bool_res = i_rs1 | op_b;
         default:   bool_res = i_rs1 & op_b;
      endcase
   end

   assign o_rd = (alu.rd_sel == RD_BOOL) ? bool_res : sum;

endmodule

// ==== source/serv_decode.sv ====
`timescale 1ns/10ps

module serv_decode
   import serv_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst_n,
   input  word_t      i_ibus_rdt,
   input  logic       i_ibus_ack,
   serv_cnt_if.user   cnt,
   serv_alu_if.decode alu,
   output reg_addr_t  o_rs1_addr,
   output reg_addr_t  o_rs2_addr,
   output reg_addr_t  o_rd_addr,
   output logic       o_rd_en,
   output logic       o_branch_op,
   output logic       o_jump,
   output logic       o_take_branch
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   // Full immediate for the instruction format
   function automatic word_t imm_of(word_t ir);
      word_t imm;
      case (ir[6:0])
         OPC_LUI:    imm = {ir[31:12], 12'b0};
         OPC_BRANCH: imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
         OPC_JAL:    imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
         default:    imm = {{20{ir[31]}}, ir[31:20]};
      endcase
      return imm;
   endfunction

   word_t      ir_q;
   word_t      imm_q;
   logic [2:0] funct3;
   logic       is_op;
   logic       is_op_imm;
   logic       is_lui;
   logic       is_branch;
   logic       is_jal;
   logic       is_add;
   logic       alu_f3_ok;
   logic       eq_q;

   assign funct3    = ir_q[14:12];
   assign is_op     = (ir_q[6:0] == OPC_OP);
   assign is_op_imm = (ir_q[6:0] == OPC_OP_IMM);
   assign is_lui    = (ir_q[6:0] == OPC_LUI);
   assign is_branch = (ir_q[6:0] == OPC_BRANCH);
   assign is_jal    = (ir_q[6:0] == OPC_JAL);
   assign is_add    = (funct3 == 3'b000);

   // ADD/SUB, XOR, OR, AND; shifts and SLT fall through as NOP
   assign alu_f3_ok = is_add | (funct3[2] & (funct3[1:0] != 2'b01));

   assign o_rs1_addr = ir_q[19:15];
   assign o_rs2_addr = ir_q[24:20];
   assign o_rd_addr  = ir_q[11:7];

   assign o_rd_en     = ((is_op | is_op_imm) & alu_f3_ok) | is_lui | is_jal;
   assign o_branch_op = is_branch & (funct3[2:1] == 2'b00);
   assign o_jump      = is_jal;

   assign alu.sub       = is_op & is_add & ir_q[30];
   assign alu.bool_op   = is_lui ? BOOL_PASS : bool_op_t'(funct3[1:0]);
   assign alu.op_b_imm  = is_op_imm | is_lui;
   assign alu.op_a_zero = is_lui;
   assign alu.imm_bit   = imm_q[0];

   always_comb begin
      if (is_jal) begin
         alu.rd_sel = RD_CTRL;
      end else if ((is_op | is_op_imm) && !is_add) begin
         alu.rd_sel = RD_BOOL;
      end else begin
         alu.rd_sel = RD_SUM;
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         ir_q  <= i_ibus_rdt;
         imm_q <= imm_of(i_ibus_rdt);
      end else if (cnt.cnt_en) begin
         imm_q <= {imm_q[31], imm_q[31:1]};
      end
   end

   // Sticky equality over all 32 bits
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         eq_q <= 1'b0;
      end else if (cnt.cnt_en) begin
         eq_q <= alu.cmp_eq & (eq_q | cnt.init);
      end
   end

   // funct3[0] set for BNE
   assign o_take_branch = o_branch_op & (eq_q ^ funct3[0]);

endmodule

// ==== source/serv_state.sv ====
`timescale 1ns/10ps
`include "serv_params.svh"

module serv_state
   import serv_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   input  logic      i_ibus_ack,
   input  logic      i_rf_ready,
   output logic      o_ibus_cyc,
   output logic      o_rf_rreq,
   serv_cnt_if.state cnt
);

   state_e state_q;
   state_e state_d;
   cnt_t   cnt_q;
   logic   cyc_q;
   logic   exec;
   logic   last;

   assign exec = (state_q == ST_EXEC);
   assign last = (cnt_q == cnt_t'(`SERV_CNT_LAST));

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_FETCH: begin
            if (cyc_q && i_ibus_ack) begin
               state_d = ST_RF_REQ;
            end
         end
         ST_RF_REQ: begin
            state_d = ST_RF_WAIT;
         end
         ST_RF_WAIT: begin
            if (i_rf_ready) begin
               state_d = ST_EXEC;
            end
         end
         ST_EXEC: begin
            if (last) begin
               state_d = ST_PC_UPD;
            end
         end
         default: begin
            state_d = ST_FETCH;
         end
      endcase
   end

   // Bus request registered so it stays low during reset
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= ST_FETCH;
         cyc_q   <= 1'b0;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         cyc_q   <= (state_d == ST_FETCH);
         if (exec) begin
            cnt_q <= cnt_q + cnt_t'(1);
         end
      end
   end

   assign o_ibus_cyc = cyc_q;
   assign o_rf_rreq  = (state_q == ST_RF_REQ);

   assign cnt.cnt_en = exec;
   assign cnt.cnt    = cnt_q;
   assign cnt.init   = exec & (cnt_q == '0);
   assign cnt.done   = exec & last;

   // One request at a time on the shared buses
   assert property (@(posedge clk) disable iff (!i_rst_n)
      o_rf_rreq |-> !o_ibus_cyc);

   // Counter frozen outside execute, also while waiting on ack or ready
   assert property (@(posedge clk) disable iff (!i_rst_n)
      !exec |=> $stable(cnt_q));

endmodule

// ==== source/serv_intf.sv ====
`timescale 1ns/10ps

// Serial bit counter, shared by all execute stages
interface serv_cnt_if
   import serv_pkg::*;
();

   logic cnt_en;
   cnt_t cnt;
   logic init;
   logic done;

   modport state (output cnt_en, output cnt, output init, output done);
   modport user  (input cnt_en, input cnt, input init, input done);

endinterface

// ALU controls from decode, equality result back
interface serv_alu_if
   import serv_pkg::*;
();

   logic     sub;
   bool_op_t bool_op;
   logic     op_b_imm;
   logic     op_a_zero;
   rd_sel_t  rd_sel;
   logic     imm_bit;
   logic     cmp_eq;

   modport decode (
      output sub, output bool_op, output op_b_imm, output op_a_zero,
      output rd_sel, output imm_bit, input cmp_eq
   );

   modport alu (
      input sub, input bool_op, input op_b_imm, input op_a_zero,
      input rd_sel, input imm_bit, output cmp_eq
   );

endinterface

// ==== source/serv_pkg.sv ====
`include "serv_params.svh"

package serv_pkg;

   typedef logic [`SERV_XLEN-1:0]         word_t;
   typedef logic [4:0]                    reg_addr_t;
   typedef logic [$clog2(`SERV_XLEN)-1:0] cnt_t;

   // Boolean unit function, encoded like funct3[1:0]
   typedef logic [1:0] bool_op_t;

   localparam bool_op_t BOOL_XOR  = 2'b00;
   localparam bool_op_t BOOL_PASS = 2'b01;
   localparam bool_op_t BOOL_OR   = 2'b10;
   localparam bool_op_t BOOL_AND  = 2'b11;

   // Source of the rd bit
   typedef logic [1:0] rd_sel_t;

   localparam rd_sel_t RD_SUM  = 2'd0;
   localparam rd_sel_t RD_BOOL = 2'd1;
   localparam rd_sel_t RD_CTRL = 2'd2;

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_RF_REQ,
      ST_RF_WAIT,
      ST_EXEC,
      ST_PC_UPD
   } state_e;

endpackage

// ==== source/serv_params.svh ====
`ifndef SERV_PARAMS_SVH
`define SERV_PARAMS_SVH

// Address of the first fetch after reset
`define SERV_RESET_PC 32'h0000_0000

// Data path width
`define SERV_XLEN 32

// Index of the last serial cycle of an instruction
`define SERV_CNT_LAST 31

`endif
